// File: rtl/bp_cfg.svh
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// weight width, sums wrap at this width too
`define BP_W_BITS 8

// number of global history bits per perceptron
`define BP_HIST_LEN 12

// table rows are indexed by pc[5:2]
`define BP_INDEX_BITS 4

// train while the output magnitude is below this
`define BP_THETA 37

// btb tag is pc[31:6], the bits above the index
`define BP_BTB_TAG_BITS 26

`endif

// File: rtl/rv32i_types_pkg.sv
package rv32i_types_pkg;

    // one instruction address or data word
    typedef logic [31:0] rv32i_word;

    // rv32i major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        // conditional branches, the only class the predictor trains on
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } opcode_t;

endpackage : rv32i_types_pkg

// File: rtl/bp_types_pkg.sv
`include "bp_cfg.svh"

package bp_types_pkg;

    // one signed perceptron weight, also the dot product width
    typedef logic signed [`BP_W_BITS-1:0] weight_t;

    // history weights in [0 .. len-1], bias weight in the last slot
    typedef weight_t weight_vec_t [`BP_HIST_LEN+1];

    // global outcome history
    // bit 0 holds the newest resolved branch
    typedef logic [`BP_HIST_LEN-1:0] history_t;

    // perceptron table and btb row select, taken from pc[5:2]
    typedef logic [`BP_INDEX_BITS-1:0] pt_index_t;

endpackage : bp_types_pkg

// File: rtl/perceptron_table.sv
`timescale 1ns/1ns

`include "bp_cfg.svh"

module perceptron_table (
    input  logic                      clk,
    input  logic                      rst_n,
    // fetch side read port
    input  bp_types_pkg::pt_index_t   r1_index,
    output bp_types_pkg::weight_vec_t perc1_out,
    // resolve side read port, shared with the write address
    input  bp_types_pkg::pt_index_t   r2_index,
    output bp_types_pkg::weight_vec_t perc2_out,
    input  logic                      wr_en,
    input  bp_types_pkg::weight_vec_t perc2_in
);

    import bp_types_pkg::*;

    // one row per index value
    localparam int entries = 1 << `BP_INDEX_BITS;

    // weight storage, row then weight
    weight_vec_t vecs [entries];

    // both reads are plain combinational lookups
    assign perc1_out = vecs[r1_index];
    assign perc2_out = vecs[r2_index];

    // zero every weight on reset
    // otherwise write back the trained row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int e = 0; e < entries; e++) begin
                for (int w = 0; w <= `BP_HIST_LEN; w++) begin
                    vecs[e][w] <= '0;
                end
            end
        end else if (wr_en) begin
            // row read on port 2 this cycle is the one replaced
            vecs[r2_index] <= perc2_in;
        end
    end

endmodule : perceptron_table

// File: rtl/perceptron_dir.sv
`timescale 1ns/1ns

`include "bp_cfg.svh"

module perceptron_dir (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    // fetch side
    input  rv32i_types_pkg::rv32i_word if_pc,
    output bp_types_pkg::weight_t    if_y_out,
    output logic                     dir_taken,
    // resolve side
    input  logic                     ex_branch,
    input  rv32i_types_pkg::rv32i_word exmem_pc,
    input  logic                     exmem_br_en,
    input  logic                     exmem_bp_br_en,
    input  bp_types_pkg::weight_t    exmem_y_out
);

    import bp_types_pkg::*;

    // magnitude limit for training on a correct prediction
    localparam logic [`BP_W_BITS-1:0] theta = `BP_THETA;

    // rows from the table
    weight_vec_t perc1_out;
    weight_vec_t perc2_out;
    // trained row going back in
    weight_vec_t perc2_in;
    // per weight terms of the dot product
    weight_vec_t terms;

    history_t ghr_q;

    weight_t acc;
    logic [`BP_W_BITS-1:0] y_mag;
    logic mispredict;
    logic pt_wr_en;
    logic ghr_wr_en;

    perceptron_table u_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .r1_index  (if_pc[`BP_INDEX_BITS+1:2]),
        .perc1_out (perc1_out),
        .r2_index  (exmem_pc[`BP_INDEX_BITS+1:2]),
        .perc2_out (perc2_out),
        .wr_en     (pt_wr_en),
        .perc2_in  (perc2_in)
    );

    // dot product against the history in +1 / -1 form
    // a zero history bit uses the inverted weight, the cheap negate
    always_comb begin
        for (int i = 0; i < `BP_HIST_LEN; i++) begin
            terms[i] = ghr_q[i] ? perc1_out[i] : ~perc1_out[i];
        end
        // bias goes in unchanged
        terms[`BP_HIST_LEN] = perc1_out[`BP_HIST_LEN];
        acc = '0;
        for (int i = 0; i <= `BP_HIST_LEN; i++) begin
            acc = acc + terms[i];
        end
    end

    assign if_y_out  = acc;
    // taken only for a strictly positive sum
    assign dir_taken = (acc > weight_t'(0));

    // absolute value of the output the branch was predicted with
    // -128 comes out as 128, which is never below theta
    assign y_mag = exmem_y_out[`BP_W_BITS-1] ? (~exmem_y_out + 1'b1) : exmem_y_out;

    assign mispredict = (exmem_bp_br_en != exmem_br_en);

    // train on a wrong direction or a weak correct one
    assign pt_wr_en  = load && ex_branch && (mispredict || (y_mag < theta));
    // history moves on every resolved branch
    assign ghr_wr_en = load && ex_branch;

    // step each weight toward agreement with the outcome
    // uses the history the branch was resolved against, wraps at the width
    always_comb begin
        for (int i = 0; i < `BP_HIST_LEN; i++) begin
            if (exmem_br_en == ghr_q[i]) begin
                perc2_in[i] = perc2_out[i] + weight_t'(1);
            end else begin
                perc2_in[i] = perc2_out[i] - weight_t'(1);
            end
        end
        if (exmem_br_en) begin
            perc2_in[`BP_HIST_LEN] = perc2_out[`BP_HIST_LEN] + weight_t'(1);
        end else begin
            perc2_in[`BP_HIST_LEN] = perc2_out[`BP_HIST_LEN] - weight_t'(1);
        end
    end

    // global history register, newest outcome into bit 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else if (ghr_wr_en) begin
            ghr_q <= {ghr_q[`BP_HIST_LEN-2:0], exmem_br_en};
        end
    end

endmodule : perceptron_dir

// File: rtl/branch_target_buffer.sv
`timescale 1ns/1ns

`include "bp_cfg.svh"

module branch_target_buffer (
    input  logic                       clk,
    input  logic                       rst_n,
    // lookup port
    input  rv32i_types_pkg::rv32i_word r_pc,
    output rv32i_types_pkg::rv32i_word btb_target,
    output logic                       btb_hit,
    // update port
    input  logic                       load,
    input  logic                       ex_branch,
    input  rv32i_types_pkg::rv32i_word w_pc,
    input  rv32i_types_pkg::rv32i_word target_in
);

    import rv32i_types_pkg::*;

    localparam int entries = 1 << `BP_INDEX_BITS;
    // lowest pc bit that is part of the tag
    localparam int tag_lsb = `BP_INDEX_BITS + 2;

    // per entry tag, target and valid
    logic [`BP_BTB_TAG_BITS-1:0] tag_q [entries];
    rv32i_word                   target_q [entries];
    logic [entries-1:0]          valid_q;

    logic [`BP_INDEX_BITS-1:0]   r_index;
    logic [`BP_INDEX_BITS-1:0]   w_index;
    logic [`BP_BTB_TAG_BITS-1:0] r_tag;
    logic [`BP_BTB_TAG_BITS-1:0] w_tag;
    logic                        wr_en;

    // split the pcs into row select and tag
    assign r_index = r_pc[tag_lsb-1:2];
    assign r_tag   = r_pc[31:tag_lsb];
    assign w_index = w_pc[tag_lsb-1:2];
    assign w_tag   = w_pc[31:tag_lsb];

    // lookup and compare
    assign btb_target = target_q[r_index];
    assign btb_hit    = valid_q[r_index] && (tag_q[r_index] == r_tag);

    // every resolved branch refreshes its row, taken or not
    assign wr_en = load && ex_branch;

    // valid bits are the only state reset clears
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[w_index] <= 1'b1;
        end
    end

    // tag and target rows
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[w_index]    <= w_tag;
            target_q[w_index] <= target_in;
        end
    end

endmodule : branch_target_buffer

// File: rtl/bp_resolve.sv
`timescale 1ns/1ns

module bp_resolve (
    // fetch side
    input  rv32i_types_pkg::rv32i_word if_pc,
    input  logic                       dir_taken,
    input  logic                       btb_hit,
    input  rv32i_types_pkg::rv32i_word btb_target,
    output rv32i_types_pkg::rv32i_word if_bp_target,
    // resolve side
    input  rv32i_types_pkg::opcode_t   exmem_opcode,
    input  logic                       exmem_br_en,
    input  logic                       exmem_bp_br_en,
    input  rv32i_types_pkg::rv32i_word exmem_alu_out,
    input  rv32i_types_pkg::rv32i_word exmem_bp_target,
    output logic                       ex_branch,
    output logic                       bp_rst
);

    import rv32i_types_pkg::*;

    logic dir_wrong;
    logic target_wrong;

    // next fetch address
    // btb target only for a predicted taken branch that hits
    assign if_bp_target = (dir_taken && btb_hit) ? btb_target : if_pc + 32'd4;

    // single opcode decode, feeds both updaters and the redirect
    assign ex_branch = (exmem_opcode == op_br);

    // direction disagreed with the resolved outcome
    assign dir_wrong = (exmem_bp_br_en != exmem_br_en);

    // both taken but fetch went somewhere else
    assign target_wrong = exmem_bp_br_en && exmem_br_en && (exmem_alu_out != exmem_bp_target);

    // flush the younger stages on either kind of miss
    assign bp_rst = ex_branch && (dir_wrong || target_wrong);

endmodule : bp_resolve

// File: rtl/perceptron_bp.sv
`timescale 1ns/1ns

module perceptron_bp (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    // IF stage
    input  rv32i_types_pkg::rv32i_word if_pc,
    output logic                       if_bp_br_en,
    output bp_types_pkg::weight_t      if_y_out,
    output rv32i_types_pkg::rv32i_word if_bp_target,
    output logic                       btb_hit,
    output logic                       bp_rst,
    // EX/MEM stage
    input  rv32i_types_pkg::rv32i_word exmem_pc,
    input  logic                       exmem_br_en,
    input  rv32i_types_pkg::opcode_t   exmem_opcode,
    input  rv32i_types_pkg::rv32i_word exmem_alu_out,
    input  logic                       exmem_bp_br_en,
    input  bp_types_pkg::weight_t      exmem_y_out,
    input  rv32i_types_pkg::rv32i_word exmem_bp_target
);

    import rv32i_types_pkg::*;

    // btb lookup result into the target select
    rv32i_word btb_target;
    // decoded branch from the resolve stage
    logic      ex_branch;

    // direction predictor, taken decision goes straight out
    perceptron_dir u_dir (
        .clk            (clk),
        .rst_n          (rst_n),
        .load           (load),
        .if_pc          (if_pc),
        .if_y_out       (if_y_out),
        .dir_taken      (if_bp_br_en),
        .ex_branch      (ex_branch),
        .exmem_pc       (exmem_pc),
        .exmem_br_en    (exmem_br_en),
        .exmem_bp_br_en (exmem_bp_br_en),
        .exmem_y_out    (exmem_y_out)
    );

    // target store, learns the resolved alu target
    branch_target_buffer u_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .r_pc       (if_pc),
        .btb_target (btb_target),
        .btb_hit    (btb_hit),
        .load       (load),
        .ex_branch  (ex_branch),
        .w_pc       (exmem_pc),
        .target_in  (exmem_alu_out)
    );

    // next pc select and redirect
    bp_resolve u_resolve (
        .if_pc           (if_pc),
        .dir_taken       (if_bp_br_en),
        .btb_hit         (btb_hit),
        .btb_target      (btb_target),
        .if_bp_target    (if_bp_target),
        .exmem_opcode    (exmem_opcode),
        .exmem_br_en     (exmem_br_en),
        .exmem_bp_br_en  (exmem_bp_br_en),
        .exmem_alu_out   (exmem_alu_out),
        .exmem_bp_target (exmem_bp_target),
        .ex_branch       (ex_branch),
        .bp_rst          (bp_rst)
    );

endmodule : perceptron_bp

// File: testbench/tb_perceptron_bp.sv
`timescale 1ns/1ns

`include "bp_cfg.svh"

module tb_perceptron_bp;

    import rv32i_types_pkg::*;
    import bp_types_pkg::*;

    localparam int n_cycles = 4000;
    // edges in the wrap phase, enough to carry any weight past +127
    localparam int n_wrap = 300;
    localparam int n_branches = 8;
    localparam int rows = 1 << `BP_INDEX_BITS;

    logic clk;
    logic rst_n;
    logic load;
    rv32i_word if_pc;
    logic if_bp_br_en;
    weight_t if_y_out;
    rv32i_word if_bp_target;
    logic btb_hit;
    logic bp_rst;
    rv32i_word exmem_pc;
    logic exmem_br_en;
    opcode_t exmem_opcode;
    rv32i_word exmem_alu_out;
    logic exmem_bp_br_en;
    weight_t exmem_y_out;
    rv32i_word exmem_bp_target;

    // reference weights, history and btb
    logic signed [`BP_W_BITS-1:0] m_w [rows][`BP_HIST_LEN+1];
    logic [`BP_HIST_LEN-1:0] m_ghr;
    logic [`BP_BTB_TAG_BITS-1:0] m_tag [rows];
    rv32i_word m_tgt [rows];
    logic m_valid [rows];

    // fixed branch set with per branch target and taken bias in percent
    rv32i_word br_pc [n_branches];
    rv32i_word br_tgt [n_branches];
    int br_bias [n_branches];

    // fetch record and the first stage behind it
    opcode_t f_op;
    logic f_br_en;
    rv32i_word f_alu;
    weight_t f_y;
    logic f_bp_en;
    rv32i_word f_bp_tgt;
    rv32i_word s1_pc;
    opcode_t s1_op;
    logic s1_br_en;
    rv32i_word s1_alu;
    weight_t s1_y;
    logic s1_bp_en;
    rv32i_word s1_bp_tgt;

    // stall tracking for the compare process
    logic prev_ok;
    logic prev_load;
    weight_t prev_y;
    rv32i_word prev_tgt;

    integer seed;

    perceptron_bp u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .load            (load),
        .if_pc           (if_pc),
        .if_bp_br_en     (if_bp_br_en),
        .if_y_out        (if_y_out),
        .if_bp_target    (if_bp_target),
        .btb_hit         (btb_hit),
        .bp_rst          (bp_rst),
        .exmem_pc        (exmem_pc),
        .exmem_br_en     (exmem_br_en),
        .exmem_opcode    (exmem_opcode),
        .exmem_alu_out   (exmem_alu_out),
        .exmem_bp_br_en  (exmem_bp_br_en),
        .exmem_y_out     (exmem_y_out),
        .exmem_bp_target (exmem_bp_target)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // limit covers reset plus both phases plus slack
    initial begin
        #((16 + n_cycles + n_wrap + 100) * 100);
        $display("timeout, the stimulus did not finish in time");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // +1/-1 history dot product where a clear bit counts as -w-1
    function automatic logic signed [`BP_W_BITS-1:0] ref_dot(
        input logic [`BP_INDEX_BITS-1:0] row, input logic [`BP_HIST_LEN-1:0] hist);
        int sum;
        sum = int'(m_w[row][`BP_HIST_LEN]);
        for (int i = 0; i < `BP_HIST_LEN; i++) begin
            if (hist[i]) begin
                sum += int'(m_w[row][i]);
            end else begin
                sum += -int'(m_w[row][i]) - 1;
            end
        end
        return sum[`BP_W_BITS-1:0];
    endfunction

    task automatic compare_outputs();
        logic [`BP_INDEX_BITS-1:0] idx;
        logic signed [`BP_W_BITS-1:0] exp_y;
        logic exp_taken;
        logic exp_hit;
        rv32i_word exp_tgt;
        logic exp_rst;
        idx = if_pc[`BP_INDEX_BITS+1:2];
        exp_y = ref_dot(idx, m_ghr);
        exp_taken = (exp_y > 0);
        exp_hit = m_valid[idx] && (m_tag[idx] == if_pc[31:`BP_INDEX_BITS+2]);
        exp_tgt = (exp_taken && exp_hit) ? m_tgt[idx] : if_pc + 32'd4;
        // redirect on wrong direction or wrong taken target
        exp_rst = (exmem_opcode == op_br) &&
                  ((exmem_bp_br_en != exmem_br_en) ||
                   (exmem_br_en && exmem_bp_br_en && (exmem_alu_out != exmem_bp_target)));
        check("if_y_out", 32'(exp_y), 32'(if_y_out));
        check("if_bp_br_en", 32'(exp_taken), 32'(if_bp_br_en));
        check("btb_hit", 32'(exp_hit), 32'(btb_hit));
        check("if_bp_target", exp_tgt, if_bp_target);
        check("bp_rst", 32'(exp_rst), 32'(bp_rst));
        // nothing may move across a stalled edge
        if (prev_ok && !prev_load) begin
            check("stall if_y_out", 32'(prev_y), 32'(if_y_out));
            check("stall if_bp_target", prev_tgt, if_bp_target);
        end
        prev_ok = 1'b1;
        prev_load = load;
        prev_y = if_y_out;
        prev_tgt = if_bp_target;
        // fetch stage view carried down the pipe
        f_y = if_y_out;
        f_bp_en = if_bp_br_en;
        f_bp_tgt = if_bp_target;
    endtask

    // next state as the dut holds it after the coming edge
    task automatic update_model();
        logic [`BP_INDEX_BITS-1:0] row;
        int mag;
        if (load && exmem_opcode == op_br) begin
            row = exmem_pc[`BP_INDEX_BITS+1:2];
            mag = int'(exmem_y_out);
            if (mag < 0) begin
                mag = -mag;
            end
            if ((exmem_bp_br_en != exmem_br_en) || (mag < `BP_THETA)) begin
                for (int i = 0; i < `BP_HIST_LEN; i++) begin
                    if (exmem_br_en == m_ghr[i]) begin
                        m_w[row][i] = m_w[row][i] + 8'sd1;
                    end else begin
                        m_w[row][i] = m_w[row][i] - 8'sd1;
                    end
                end
                if (exmem_br_en) begin
                    m_w[row][`BP_HIST_LEN] = m_w[row][`BP_HIST_LEN] + 8'sd1;
                end else begin
                    m_w[row][`BP_HIST_LEN] = m_w[row][`BP_HIST_LEN] - 8'sd1;
                end
            end
            m_ghr = {m_ghr[`BP_HIST_LEN-2:0], exmem_br_en};
            m_valid[row] = 1'b1;
            m_tag[row] = exmem_pc[31:`BP_INDEX_BITS+2];
            m_tgt[row] = exmem_alu_out;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            compare_outputs();
            update_model();
        end
    end

    // next fetch is a known branch or some other instruction
    task automatic next_fetch();
        int k;
        if (($random(seed) & 3) == 0) begin
            if_pc = $random(seed) & 32'h0000_fffc;
            case ($unsigned($random(seed)) % 4)
                0: f_op = op_imm;
                1: f_op = op_load;
                2: f_op = op_store;
                default: f_op = op_reg;
            endcase
            f_br_en = $random(seed) & 1;
            f_alu = $random(seed) & 32'h0000_fffc;
        end else begin
            k = $unsigned($random(seed)) % n_branches;
            if_pc = br_pc[k];
            f_op = op_br;
            f_br_en = ($unsigned($random(seed)) % 100) < br_bias[k];
            f_alu = br_tgt[k];
            // odd target now and then for the wrong target redirect
            if (($random(seed) & 15) == 0) begin
                f_alu = $random(seed) & 32'h0000_fffc;
            end
        end
    endtask

    task automatic drive_exmem();
        exmem_pc = s1_pc;
        exmem_opcode = s1_op;
        exmem_br_en = s1_br_en;
        exmem_alu_out = s1_alu;
        exmem_y_out = s1_y;
        exmem_bp_br_en = s1_bp_en;
        exmem_bp_target = s1_bp_tgt;
    endtask

    initial begin
        seed = 32'hfd4a715b;
        prev_ok = 1'b0;
        prev_load = 1'b1;
        prev_y = '0;
        prev_tgt = '0;
        rst_n = 1'b0;
        load = 1'b0;
        if_pc = '0;
        m_ghr = '0;
        for (int r = 0; r < rows; r++) begin
            for (int i = 0; i <= `BP_HIST_LEN; i++) begin
                m_w[r][i] = '0;
            end
            m_valid[r] = 1'b0;
            m_tag[r] = '0;
            m_tgt[r] = '0;
        end
        // small address range so rows and tags collide
        for (int k = 0; k < n_branches; k++) begin
            br_pc[k] = $random(seed) & 32'h0000_01fc;
            br_tgt[k] = $random(seed) & 32'h0000_fffc;
            br_bias[k] = $unsigned($random(seed)) % 101;
        end
        // empty stages carry a non-branch
        s1_pc = '0;
        s1_op = op_imm;
        s1_br_en = 1'b0;
        s1_alu = '0;
        s1_y = '0;
        s1_bp_en = 1'b0;
        s1_bp_tgt = '0;
        f_op = op_imm;
        f_br_en = 1'b0;
        f_alu = '0;
        f_y = '0;
        f_bp_en = 1'b0;
        f_bp_tgt = '0;
        drive_exmem();
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;
        load = 1'b1;
        next_fetch();
        for (int c = 0; c < n_cycles; c++) begin
            @(posedge clk);
            #5;
            // the pipe only moves on an edge with load high
            if (load) begin
                drive_exmem();
                s1_pc = if_pc;
                s1_op = f_op;
                s1_br_en = f_br_en;
                s1_alu = f_alu;
                s1_y = f_y;
                s1_bp_en = f_bp_en;
                s1_bp_tgt = f_bp_tgt;
                next_fetch();
            end
            // roughly one stalled cycle in eight
            load = ($random(seed) & 7) != 0;
        end
        // next edge runs with load high so the inputs may change after it
        load = 1'b1;
        @(posedge clk);
        #5;
        // one row mispredicted on every edge until its weights wrap
        if_pc = br_pc[0];
        exmem_pc = br_pc[0];
        exmem_opcode = op_br;
        exmem_br_en = 1'b1;
        exmem_bp_br_en = 1'b0;
        exmem_alu_out = br_tgt[0];
        exmem_y_out = '0;
        exmem_bp_target = br_pc[0] + 32'd4;
        repeat (n_wrap) @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule : tb_perceptron_bp

// File: list.f
+incdir+rtl
rtl/rv32i_types_pkg.sv
rtl/bp_types_pkg.sv
rtl/perceptron_table.sv
rtl/perceptron_dir.sv
rtl/branch_target_buffer.sv
rtl/bp_resolve.sv
rtl/perceptron_bp.sv
testbench/tb_perceptron_bp.sv

// File: run.sh
#!/bin/sh
# build and run the perceptron predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_perceptron_bp -f list.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
